// File: Makefile
# Verilator build and run of the cartridge slot testbench

VERILATOR ?= verilator
TOP       ?= md_cart_tb
FILELIST  ?= md_cart.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All checks passed

SOURCES := $(wildcard hw/*.sv) $(wildcard verif/*.sv) $(wildcard verif/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: hw/bank_mapper.sv
// Mapper stage holding the bank, save RAM enable and write-protect registers and forming ROM addresses
`timescale 1ns/1ps

module bank_mapper #(
	parameter int ROM_AW = 23
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   bank_wr,
	input  logic                   sram_en_wr,
	input  logic                   prot_wr,
	input  md_cart_pkg::bus_addr_t bus_addr,
	input  md_cart_pkg::word_t     bus_wdata,
	input  md_cart_pkg::bus_addr_t rd_addr,
	input  md_cart_pkg::rom_addr_t rom_mask,
	input  logic                   bus_lwr,
	input  logic                   bus_uwr,
	input  logic                   schan_quirk,
	output logic                   bank_sram,
	output md_cart_pkg::rom_addr_t rom_rd_addr,
	output logic                   cpu_wr_en,
	output md_cart_pkg::rom_addr_t cpu_wr_addr
);
	import md_cart_pkg::*;

	// Words the ROM memory can actually hold
	localparam rom_addr_t AW_MASK = rom_addr_t'((64'd1 << ROM_AW) - 64'd1);

	bank_t     bank [BANK_SLOTS];
	logic      bank_use;
	logic      rom_prot;
	rom_addr_t rd_map;
	rom_addr_t wr_map;

	// ========================================================================
	// Mapper registers
	// ========================================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < BANK_SLOTS; i++)
				bank[i] <= bank_t'(i);
			bank_use  <= 1'b0;
			bank_sram <= 1'b0;
			rom_prot  <= 1'b1;
		end else begin
			if (bank_wr) begin
				bank_use <= 1'b1;
				bank[bus_addr[2:0]] <= bus_wdata[5:0];
			end
			if (sram_en_wr)
				bank_sram <= bus_wdata[0];
			if (prot_wr)
				rom_prot <= bus_wdata[0];
		end
	end

	// Slot picked by byte address bits 21..19 with the page offset kept
	always_comb begin
		if (bank_use) begin
			rd_map = {bank[rd_addr[20:18]], rd_addr[17:0]};
			wr_map = {bank[bus_addr[20:18]], bus_addr[17:0]};
		end else begin
			rd_map = rom_addr_t'(rd_addr);
			wr_map = rom_addr_t'(bus_addr);
		end
	end

	// Mirroring over the loaded image
	assign rom_rd_addr = rd_map & rom_mask & AW_MASK;
	assign cpu_wr_addr = wr_map & rom_mask & AW_MASK;

	// RAM-as-ROM cart is writable below $400000 once unprotected
	assign cpu_wr_en = schan_quirk & (bus_lwr | bus_uwr) &
		(bus_addr[22:21] == 2'b00) & ~rom_prot;

endmodule

// File: hw/cart_decode.sv
// Bus decode stage: catches read starts, latches the read address and raises selects
`timescale 1ns/1ps

module cart_decode (
	input  logic                   clk,
	input  logic                   reset,
	input  md_cart_pkg::bus_addr_t bus_addr,
	input  logic                   bus_oe,
	input  logic                   bus_lwr,
	input  logic                   bus_time,
	input  md_cart_pkg::rom_addr_t rom_size,
	input  logic                   big_rom,
	input  logic                   noram_quirk,
	input  logic                   schan_quirk,
	input  logic                   bank_sram,
	output logic                   rd_start,
	output logic                   rd_sram,
	output md_cart_pkg::bus_addr_t rd_addr,
	output logic                   sram_cs,
	output logic                   bank_wr,
	output logic                   sram_en_wr,
	output logic                   prot_wr
);
	import md_cart_pkg::*;

	logic oe_q;
	logic rd_go;
	logic sram_win;
	logic slot_sel;

	assign rd_go = bus_oe & ~oe_q;

	// $200000 window, either switched in or past the end of the image
	assign sram_win = (bus_addr[22:20] == 3'b001) &&
		(bank_sram || rom_addr_t'(bus_addr) >= rom_size) && !noram_quirk;
	assign sram_cs = sram_win & bus_lwr;

	// ========================================================================
	// $A130xx register strobes
	// ========================================================================

	// Slot 0 is the save RAM enable, slots 1..7 are banks
	assign slot_sel = |bus_addr[2:0];

	assign bank_wr    = bus_lwr & bus_time & big_rom & slot_sel;
	assign sram_en_wr = bus_lwr & bus_time & (big_rom ? !slot_sel : !schan_quirk);
	assign prot_wr    = schan_quirk & bus_time & bus_lwr & (bus_addr[6:0] == PROT_REG);

	always_ff @(posedge clk) begin
		if (reset) begin
			oe_q     <= 1'b0;
			rd_start <= 1'b0;
			rd_sram  <= 1'b0;
		end else begin
			oe_q     <= bus_oe;
			rd_start <= rd_go;
			rd_sram  <= rd_go & sram_win;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_go)
			rd_addr <= bus_addr;
	end

	// Save RAM and mapper registers live in separate address spaces
	a_sram_vs_regs : assert property (@(posedge clk) disable iff (reset)
		sram_cs |-> !(bank_wr || sram_en_wr || prot_wr))
		else $error("save RAM write collides with a register strobe");

endmodule

// File: hw/cart_result.sv
// Read result stage: picks ROM or save RAM data and raises the bus acknowledge
`timescale 1ns/1ps

module cart_result (
	input  logic               clk,
	input  logic               reset,
	input  logic               rd_start,
	input  logic               rd_sram,
	input  md_cart_pkg::word_t rom_data,
	input  md_cart_pkg::byte_t sram_data,
	output md_cart_pkg::word_t bus_rdata,
	output logic               bus_ack
);

	logic start_q;
	logic sram_q;

	// Flags line up with the memory read cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			start_q <= 1'b0;
			sram_q  <= 1'b0;
		end else begin
			start_q <= rd_start;
			sram_q  <= rd_sram;
		end
	end

	// 8-bit RAM shows up on both byte lanes
	assign bus_rdata = sram_q ? {sram_data, sram_data} : rom_data;
	assign bus_ack   = start_q;

endmodule

// File: hw/header_detect.sv
// Watches the download stream for the product code and raises the cartridge quirk flags
`timescale 1ns/1ps

module header_detect (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  dl_active,
	input  logic                  dl_wr,
	input  md_cart_pkg::dl_addr_t dl_addr,
	input  md_cart_pkg::word_t    dl_data,
	output logic                  noram_quirk,
	output logic                  schan_quirk,
	output logic                  sram00_quirk
);
	import md_cart_pkg::*;

	logic        dl_q;
	logic        dl_rise;
	logic        hdr_wr;
	logic [63:0] cart_id;
	word_t       swapped;

	assign dl_rise = dl_active & ~dl_q;
	assign hdr_wr  = dl_active & dl_wr;

	// Header text is stored big-endian, download words are little-endian
	assign swapped = {dl_data[7:0], dl_data[15:8]};

	always_ff @(posedge clk) begin
		if (reset)
			dl_q <= 1'b0;
		else
			dl_q <= dl_active;
	end

	// Product code capture, first and last words are half used
	always_ff @(posedge clk) begin
		if (hdr_wr) begin
			if (dl_addr == HDR_ID_FIRST)
				cart_id[63:56] <= dl_data[15:8];
			else if (dl_addr == HDR_ID_FIRST + 25'd2)
				cart_id[55:40] <= swapped;
			else if (dl_addr == HDR_ID_FIRST + 25'd4)
				cart_id[39:24] <= swapped;
			else if (dl_addr == HDR_ID_FIRST + 25'd6)
				cart_id[23:8] <= swapped;
			else if (dl_addr == HDR_ID_LAST)
				cart_id[7:0] <= dl_data[7:0];
		end
	end

	// ========================================================================
	// Quirk flags
	// ========================================================================

	always_ff @(posedge clk) begin
		if (dl_rise) begin
			noram_quirk  <= 1'b0;
			schan_quirk  <= 1'b0;
			sram00_quirk <= 1'b0;
		end else if (hdr_wr && dl_addr == HDR_EVAL) begin
			// First match wins
			if (cart_id == ID_NORAM)
				noram_quirk <= 1'b1;
			else if (cart_id == ID_SCHAN)
				schan_quirk <= 1'b1;
			else if (cart_id == ID_SRAM00)
				sram00_quirk <= 1'b1;
		end
	end

endmodule

// File: hw/md_cart.sv
// Cartridge slot top level, download port and CPU bus in, read data and ready out
`timescale 1ns/1ps

module md_cart #(
	parameter int ROM_AW  = 23,
	parameter int SRAM_AW = 16
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   dl_active,
	input  logic                   dl_wr,
	input  md_cart_pkg::dl_addr_t  dl_addr,
	input  md_cart_pkg::word_t     dl_data,
	input  md_cart_pkg::bus_addr_t bus_addr,
	input  logic                   bus_oe,
	input  logic                   bus_lwr,
	input  logic                   bus_uwr,
	input  logic                   bus_time,
	input  md_cart_pkg::word_t     bus_wdata,
	output md_cart_pkg::word_t     bus_rdata,
	output logic                   bus_ack,
	output logic                   cart_ready
);
	import md_cart_pkg::*;

	logic      noram_quirk;
	logic      schan_quirk;
	logic      sram00_quirk;
	logic      ld_wr_en;
	rom_addr_t ld_wr_addr;
	word_t     ld_wr_data;
	rom_addr_t rom_size;
	rom_addr_t rom_mask;
	logic      big_rom;
	logic      rd_start;
	logic      rd_sram;
	bus_addr_t rd_addr;
	logic      sram_cs;
	logic      bank_wr;
	logic      sram_en_wr;
	logic      prot_wr;
	logic      bank_sram;
	rom_addr_t rom_rd_addr;
	logic      cpu_wr_en;
	rom_addr_t cpu_wr_addr;
	logic      rom_wr_en;
	rom_addr_t rom_wr_addr;
	word_t     rom_wr_data;
	word_t     rom_rd_data;
	byte_t     sram_rdata;

	// ========================================================================
	// Download side
	// ========================================================================

	header_detect u_header_detect (
		.clk(clk), .reset(reset), .dl_active(dl_active), .dl_wr(dl_wr),
		.dl_addr(dl_addr), .dl_data(dl_data), .noram_quirk(noram_quirk),
		.schan_quirk(schan_quirk), .sram00_quirk(sram00_quirk)
	);

	rom_loader #(.ROM_AW(ROM_AW)) u_rom_loader (
		.clk(clk), .dl_active(dl_active), .dl_wr(dl_wr), .dl_addr(dl_addr),
		.dl_data(dl_data), .wr_en(ld_wr_en), .wr_addr(ld_wr_addr), .wr_data(ld_wr_data),
		.rom_size(rom_size), .rom_mask(rom_mask), .big_rom(big_rom)
	);

	// CPU stays off the bus while a download runs
	assign rom_wr_en   = ld_wr_en | cpu_wr_en;
	assign rom_wr_addr = ld_wr_en ? ld_wr_addr : cpu_wr_addr;
	assign rom_wr_data = ld_wr_en ? ld_wr_data : bus_wdata;

	// ========================================================================
	// CPU read pipeline
	// ========================================================================

	cart_decode u_cart_decode (
		.clk(clk), .reset(reset), .bus_addr(bus_addr), .bus_oe(bus_oe),
		.bus_lwr(bus_lwr), .bus_time(bus_time), .rom_size(rom_size), .big_rom(big_rom),
		.noram_quirk(noram_quirk), .schan_quirk(schan_quirk), .bank_sram(bank_sram),
		.rd_start(rd_start), .rd_sram(rd_sram), .rd_addr(rd_addr), .sram_cs(sram_cs),
		.bank_wr(bank_wr), .sram_en_wr(sram_en_wr), .prot_wr(prot_wr)
	);

	bank_mapper #(.ROM_AW(ROM_AW)) u_bank_mapper (
		.clk(clk), .reset(reset), .bank_wr(bank_wr), .sram_en_wr(sram_en_wr),
		.prot_wr(prot_wr), .bus_addr(bus_addr), .bus_wdata(bus_wdata), .rd_addr(rd_addr),
		.rom_mask(rom_mask), .bus_lwr(bus_lwr), .bus_uwr(bus_uwr),
		.schan_quirk(schan_quirk), .bank_sram(bank_sram), .rom_rd_addr(rom_rd_addr),
		.cpu_wr_en(cpu_wr_en), .cpu_wr_addr(cpu_wr_addr)
	);

	rom_store #(.ROM_AW(ROM_AW)) u_rom_store (
		.clk(clk), .wr_en(rom_wr_en), .wr_addr(rom_wr_addr), .wr_data(rom_wr_data),
		.rd_addr(rom_rd_addr), .rd_data(rom_rd_data)
	);

	save_ram #(.SRAM_AW(SRAM_AW)) u_save_ram (
		.clk(clk), .reset(reset), .dl_active(dl_active), .fill_zero(sram00_quirk),
		.addr(bus_addr), .wdata(bus_wdata[7:0]), .wr(sram_cs), .rdata(sram_rdata),
		.ready(cart_ready)
	);

	cart_result u_cart_result (
		.clk(clk), .reset(reset), .rd_start(rd_start), .rd_sram(rd_sram),
		.rom_data(rom_rd_data), .sram_data(sram_rdata), .bus_rdata(bus_rdata),
		.bus_ack(bus_ack)
	);

endmodule

// File: hw/md_cart_pkg.sv
// Cartridge-wide types, header addresses and product codes, imported by every RTL block
package md_cart_pkg;

	// ========================================================================
	// Bus and memory widths
	// ========================================================================

	// One 16-bit word on the bus, in ROM and on download
	typedef logic [15:0] word_t;

	// One save RAM cell
	typedef logic [7:0] byte_t;

	// CPU word address, byte address bits 23..1
	typedef logic [22:0] bus_addr_t;

	// Download byte address
	typedef logic [24:0] dl_addr_t;

	// ROM word address before the memory drops the unused top bits
	typedef logic [23:0] rom_addr_t;

	// Mapper bank number, one 512 KB page
	typedef logic [5:0] bank_t;

	localparam int BANK_SLOTS = 8;

	// ========================================================================
	// Cartridge header
	// ========================================================================

	// Product code spans 0x183..0x18A, compared once 0x190 is written
	localparam dl_addr_t HDR_ID_FIRST = 25'h000182;
	localparam dl_addr_t HDR_ID_LAST  = 25'h00018a;
	localparam dl_addr_t HDR_EVAL     = 25'h000190;

	// Carts with known quirks
	localparam logic [63:0] ID_NORAM  = "T-113016";
	localparam logic [63:0] ID_SCHAN  = "T-68???-";
	localparam logic [63:0] ID_SRAM00 = " GM 0000";

	// Write-protect register inside the $A130xx window, address bits 7..1
	localparam logic [6:0] PROT_REG = 7'h78;

	// Save RAM clear sweep
	typedef enum logic [0:0] {
		IDLE,
		CLEAR
	} sweep_t;

endpackage

// File: hw/rom_loader.sv
// Download write path into ROM, tracking the loaded image size and its mirror mask
`timescale 1ns/1ps

module rom_loader #(
	parameter int ROM_AW = 23
) (
	input  logic                   clk,
	input  logic                   dl_active,
	input  logic                   dl_wr,
	input  md_cart_pkg::dl_addr_t  dl_addr,
	input  md_cart_pkg::word_t     dl_data,
	output logic                   wr_en,
	output md_cart_pkg::rom_addr_t wr_addr,
	output md_cart_pkg::word_t     wr_data,
	output md_cart_pkg::rom_addr_t rom_size,
	output md_cart_pkg::rom_addr_t rom_mask,
	output logic                   big_rom
);
	import md_cart_pkg::*;

	logic      dl_q;
	logic      dl_rise;
	rom_addr_t word_idx;
	rom_addr_t mask_base;

	assign dl_rise  = dl_active & ~dl_q;
	assign word_idx = rom_addr_t'(dl_addr[ROM_AW:1]);

	// Word goes straight to memory on the edge that samples dl_wr
	assign wr_en   = dl_active & dl_wr;
	assign wr_addr = word_idx;
	assign wr_data = dl_data;

	// A write in the start cycle must not see the old mask
	assign mask_base = dl_rise ? '0 : rom_mask;

	always_ff @(posedge clk) begin
		dl_q <= dl_active;
		if (wr_en) begin
			rom_size <= word_idx + 1'b1;
			rom_mask <= mask_base | word_idx;
		end else if (dl_rise) begin
			rom_size <= '0;
			rom_mask <= '0;
		end
	end

	// Anything at or past 4 MB needs the bank mapper
	assign big_rom = |rom_mask[23:21];

endmodule

// File: hw/rom_store.sv
// ROM image memory, one synchronous write port and one synchronous read port
`timescale 1ns/1ps

module rom_store #(
	parameter int ROM_AW = 23
) (
	input  logic                   clk,
	input  logic                   wr_en,
	input  md_cart_pkg::rom_addr_t wr_addr,
	input  md_cart_pkg::word_t     wr_data,
	input  md_cart_pkg::rom_addr_t rd_addr,
	output md_cart_pkg::word_t     rd_data
);
	import md_cart_pkg::*;

	word_t mem [2**ROM_AW];

	// Top address bits beyond the memory are dropped here
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr[ROM_AW-1:0]] <= wr_data;
	end

	// One cycle read, old data on a same-address write
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr[ROM_AW-1:0]];
	end

endmodule

// File: hw/save_ram.sv
// Byte-wide battery save RAM, swept to its blank value after every download
`timescale 1ns/1ps

module save_ram #(
	parameter int SRAM_AW = 16
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   dl_active,
	input  logic                   fill_zero,
	input  md_cart_pkg::bus_addr_t addr,
	input  md_cart_pkg::byte_t     wdata,
	input  logic                   wr,
	output md_cart_pkg::byte_t     rdata,
	output logic                   ready
);
	import md_cart_pkg::*;

	sweep_t             state;
	logic               dl_q;
	logic [SRAM_AW-1:0] sweep_addr;
	byte_t              fill;
	byte_t              mem [2**SRAM_AW];

	// Some carts expect zeroed RAM instead of erased
	assign fill = fill_zero ? 8'h00 : 8'hff;

	// ========================================================================
	// Clear sweep FSM
	// ========================================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= IDLE;
			ready      <= 1'b0;
			dl_q       <= 1'b0;
			sweep_addr <= '0;
		end else begin
			dl_q <= dl_active;
			if (dl_active) begin
				state <= IDLE;
				ready <= 1'b0;
			end else if (dl_q) begin
				state      <= CLEAR;
				sweep_addr <= '0;
			end else if (state == CLEAR) begin
				sweep_addr <= sweep_addr + 1'b1;
				// Last cell written
				if (&sweep_addr) begin
					state <= IDLE;
					ready <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == CLEAR)
			mem[sweep_addr] <= fill;
		else if (wr)
			mem[addr[SRAM_AW-1:0]] <= wdata;
		rdata <= mem[addr[SRAM_AW-1:0]];
	end

	a_no_wr_in_clear : assert property (@(posedge clk) disable iff (reset)
		(state == CLEAR) |-> !wr)
		else $error("save RAM written during clear sweep");

endmodule

// File: md_cart.f
+incdir+verif
hw/md_cart_pkg.sv
hw/header_detect.sv
hw/rom_loader.sv
hw/cart_decode.sv
hw/bank_mapper.sv
hw/rom_store.sv
hw/save_ram.sv
hw/cart_result.sv
hw/md_cart.sv
verif/md_cart_tb.sv

// File: verif/md_cart_tb_tests.svh
// Test sequences for the cartridge testbench, included inside the testbench module

	// ========================================================================
	// Plain image: readback, mirroring, erased save RAM
	// ========================================================================

	task automatic readback_test();
		int    a;
		word_t b;
		test_name = "rom_readback";
		fill_image(SMALL_WORDS, "TEST-001");
		download(SMALL_WORDS);
		for (int i = 0; i < 64; i++) begin
			a = $urandom % SMALL_WORDS;
			bus_read(bus_addr_t'(a), rom_img[img_idx_t'(a)]);
		end
		settle();

		// Past the image but below the save RAM window
		test_name = "mirroring";
		for (int i = 0; i < 32; i++) begin
			a = SMALL_WORDS + $urandom % (32'h100000 - SMALL_WORDS);
			bus_read(bus_addr_t'(a), rom_img[img_idx_t'(a & int'(img_mask))]);
		end
		settle();

		test_name = "sram_erased";
		for (int i = 0; i < 8; i++) begin
			a = 32'h100000 + $urandom % SWEEP;
			bus_read(bus_addr_t'(a), 16'hffff);
		end
		a = 32'h100000 + $urandom % SWEEP;
		b = word_t'($urandom);
		bus_write(bus_addr_t'(a), b, 1'b0);
		bus_read(bus_addr_t'(a), {b[7:0], b[7:0]});
		settle();
	endtask

	// ========================================================================
	// Save RAM that clears to zero
	// ========================================================================

	task automatic sram_zero_test();
		int    a;
		word_t b;
		test_name = "sram_zero_fill";
		fill_image(SMALL_WORDS, " GM 0000");
		download(SMALL_WORDS);
		for (int i = 0; i < 8; i++) begin
			a = 32'h100000 + $urandom % SWEEP;
			bus_read(bus_addr_t'(a), 16'h0000);
		end
		settle();
		test_name = "sram_write";
		for (int i = 0; i < 4; i++) begin
			a = 32'h100000 + $urandom % SWEEP;
			b = word_t'($urandom);
			bus_write(bus_addr_t'(a), b, 1'b0);
			bus_read(bus_addr_t'(a), {b[7:0], b[7:0]});
		end
		settle();
	endtask

	// ========================================================================
	// No save RAM: the $200000 window stays ROM
	// ========================================================================

	task automatic noram_test();
		int a;
		test_name = "noram_quirk";
		fill_image(SMALL_WORDS, "T-113016");
		download(SMALL_WORDS);
		for (int i = 0; i < 16; i++) begin
			a = 32'h100000 + $urandom % SWEEP;
			bus_read(bus_addr_t'(a), rom_img[img_idx_t'(a & int'(img_mask))]);
		end
		settle();
	endtask

	// ========================================================================
	// RAM-as-ROM cart and its protect register
	// ========================================================================

	task automatic protect_test();
		int    w;
		word_t old_word;
		word_t new_word;
		test_name = "write_protect";
		fill_image(SMALL_WORDS, "T-68???-");
		download(SMALL_WORDS);
		w        = 32'h200 + $urandom % 256;
		old_word = rom_img[img_idx_t'(w)];
		new_word = ~old_word;
		bus_write(bus_addr_t'(w), new_word, 1'b0);
		bus_read(bus_addr_t'(w), old_word);
		settle();

		// Protect register at address bits 7..1 = 0x78
		test_name = "write_unprotected";
		bus_write(23'h000078, 16'h0000, 1'b1);
		bus_write(bus_addr_t'(w), new_word, 1'b0);
		rom_img[img_idx_t'(w)] = new_word;
		bus_read(bus_addr_t'(w), new_word);
		settle();
	endtask

	// ========================================================================
	// Big image and the bank mapper
	// ========================================================================

	task automatic banking_test();
		int off;
		int n;
		test_name = "bank_default";
		fill_image(BIG_WORDS, "TEST-BIG");
		download(BIG_WORDS);
		for (int i = 0; i < 16; i++) begin
			off = $urandom % PAGE_WORDS;
			bus_read(bus_addr_t'(PAGE_WORDS + off), rom_img[img_idx_t'(PAGE_WORDS + off)]);
		end
		settle();

		// Slot 1 register, then its window shows page n
		test_name = "bank_switch";
		n = 2 + $urandom % 6;
		bus_write(23'h000001, word_t'(n), 1'b1);
		for (int i = 0; i < 32; i++) begin
			off = $urandom % PAGE_WORDS;
			bus_read(bus_addr_t'(PAGE_WORDS + off),
				rom_img[img_idx_t'(n * PAGE_WORDS + off)]);
		end
		settle();

		// Slot 0 still holds bank 0
		test_name = "bank_slot0";
		for (int i = 0; i < 8; i++) begin
			off = $urandom % PAGE_WORDS;
			bus_read(bus_addr_t'(off), rom_img[img_idx_t'(off)]);
		end
		settle();
	endtask

// File: verif/md_cart_tb.sv
// Testbench for the cartridge slot: clock, reset, download and bus tasks, read-data checks
`timescale 1ns/1ps

module md_cart_tb;
	import md_cart_pkg::*;

	localparam int ROM_AW      = 23;
	localparam int SRAM_AW     = 16;
	localparam int IMG_AW      = 22;
	localparam int SMALL_WORDS = 1024;
	localparam int BIG_WORDS   = 2**21 + 1;
	localparam int PAGE_WORDS  = 2**18;
	localparam int SWEEP       = 2**SRAM_AW;
	// Four small images and one big one, a sweep after each, slack for the bus traffic
	localparam int LIMIT_CYCLES = BIG_WORDS + 4 * SMALL_WORDS + 5 * (SWEEP + 16) + 20000;

	typedef logic [IMG_AW-1:0] img_idx_t;

	logic      clk;
	logic      reset;
	logic      dl_active;
	logic      dl_wr;
	dl_addr_t  dl_addr;
	word_t     dl_data;
	bus_addr_t bus_addr;
	logic      bus_oe;
	logic      bus_lwr;
	logic      bus_uwr;
	logic      bus_time;
	word_t     bus_wdata;
	word_t     bus_rdata;
	logic      bus_ack;
	logic      cart_ready;

	// Scoreboard of the current image
	word_t     rom_img [2**IMG_AW];
	rom_addr_t img_mask;
	word_t     exp_word;
	string     test_name;
	int        errors;
	int        reads;

	// Read starts and their expected words, two stages deep
	logic  oe_prev;
	logic  rd_edge;
	logic  rd_d1;
	logic  rd_d2;
	word_t exp_d1;
	word_t exp_d2;

	md_cart #(.ROM_AW(ROM_AW), .SRAM_AW(SRAM_AW)) dut0 (
		.clk(clk), .reset(reset), .dl_active(dl_active), .dl_wr(dl_wr),
		.dl_addr(dl_addr), .dl_data(dl_data), .bus_addr(bus_addr), .bus_oe(bus_oe),
		.bus_lwr(bus_lwr), .bus_uwr(bus_uwr), .bus_time(bus_time), .bus_wdata(bus_wdata),
		.bus_rdata(bus_rdata), .bus_ack(bus_ack), .cart_ready(cart_ready)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	assign rd_edge = bus_oe & ~oe_prev;

	always_ff @(posedge clk) begin
		if (reset) begin
			oe_prev <= 1'b0;
			rd_d1   <= 1'b0;
			rd_d2   <= 1'b0;
			exp_d1  <= '0;
			exp_d2  <= '0;
		end else begin
			oe_prev <= bus_oe;
			rd_d1   <= rd_edge;
			rd_d2   <= rd_d1;
			exp_d1  <= exp_word;
			exp_d2  <= exp_d1;
		end
	end

	// ========================================================================
	// Read checks
	// ========================================================================

	a_read_data : assert property (@(posedge clk) disable iff (reset)
		rd_d2 |-> (bus_ack && bus_rdata == exp_d2))
		else begin
			errors++;
			$display("FAIL %s: expected %h, actual %h (ack %b)", test_name,
				$sampled(exp_d2), $sampled(bus_rdata), $sampled(bus_ack));
		end

	a_ack_single : assert property (@(posedge clk) disable iff (reset)
		bus_ack |-> rd_d2)
		else begin
			errors++;
			$display("bus_ack raised without a read start two cycles earlier in %s",
				test_name);
		end

	// ========================================================================
	// Host and CPU tasks
	// ========================================================================

	// Random image with an 8-character product code at 0x183..0x18A
	task automatic fill_image(input int words, input logic [63:0] id);
		int a;
		for (int i = 0; i < words; i++)
			rom_img[img_idx_t'(i)] = word_t'($urandom);
		for (int k = 0; k < 8; k++) begin
			a = 32'h183 + k;
			// Even byte address sits in the low half
			if (a[0])
				rom_img[img_idx_t'(a >> 1)][15:8] = id[63 - 8 * k -: 8];
			else
				rom_img[img_idx_t'(a >> 1)][7:0] = id[63 - 8 * k -: 8];
		end
	endtask

	// Streams the image one word per cycle, then waits out the save RAM sweep
	task automatic download(input int words);
		int waited;
		img_mask = '0;
		@(negedge clk);
		dl_active = 1'b1;
		for (int i = 0; i < words; i++) begin
			@(negedge clk);
			dl_wr    = 1'b1;
			dl_addr  = dl_addr_t'(i * 2);
			dl_data  = rom_img[img_idx_t'(i)];
			img_mask = img_mask | rom_addr_t'(i);
		end
		@(negedge clk);
		dl_wr = 1'b0;
		assert (!cart_ready)
			else begin
				errors++;
				$display("cart_ready stayed high during the download in %s", test_name);
			end
		dl_active = 1'b0;
		waited = 0;
		while (!cart_ready && waited < SWEEP + 16) begin
			@(negedge clk);
			waited++;
		end
		assert (cart_ready && waited >= SWEEP && waited <= SWEEP + 4)
			else begin
				errors++;
				$display("cart_ready came after %0d cycles instead of one sweep in %s",
					waited, test_name);
			end
	endtask

	// Address stays on the bus through the memory cycle
	task automatic bus_read(input bus_addr_t addr, input word_t expected);
		@(negedge clk);
		bus_addr = addr;
		exp_word = expected;
		bus_oe   = 1'b1;
		@(negedge clk);
		bus_oe = 1'b0;
		reads++;
	endtask

	task automatic bus_write(input bus_addr_t addr, input word_t data, input logic reg_sel);
		@(negedge clk);
		bus_addr  = addr;
		bus_wdata = data;
		bus_time  = reg_sel;
		bus_lwr   = 1'b1;
		@(negedge clk);
		bus_lwr  = 1'b0;
		bus_time = 1'b0;
	endtask

	// Lets reads still in the pipeline finish under the current test name
	task automatic settle();
		repeat (4) @(negedge clk);
	endtask

	`include "md_cart_tb_tests.svh"

	initial begin
		void'($urandom(32'hcd52));
		errors    = 0;
		reads     = 0;
		test_name = "reset";
		reset     = 1'b1;
		dl_active = 1'b0;
		dl_wr     = 1'b0;
		dl_addr   = '0;
		dl_data   = '0;
		bus_addr  = '0;
		bus_oe    = 1'b0;
		bus_lwr   = 1'b0;
		bus_uwr   = 1'b0;
		bus_time  = 1'b0;
		bus_wdata = '0;
		exp_word  = '0;
		img_mask  = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		assert (!bus_ack && !cart_ready)
			else begin
				errors++;
				$display("bus_ack or cart_ready high right after reset");
			end

		readback_test();
		sram_zero_test();
		noram_test();
		protect_test();
		banking_test();

		$display("Reads checked: %0d, errors: %0d", reads, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (LIMIT_CYCLES) @(posedge clk);
		$display("Timeout after %0d cycles, the tests did not finish", LIMIT_CYCLES);
		$display("Checks failed");
		$finish;
	end

endmodule
